/* design/bitfield_macros.svh */
`ifndef BITFIELD_MACROS_SVH
`define BITFIELD_MACROS_SVH

// Width of every operand, control word and result
`define BF_WIDTH 32

// Number of identical lanes behind the dispatcher
`define BF_LANES 4

// Entries in the result FIFO of the collector
`define BF_FIFO_DEPTH 8

// ==============================
// AXI4-Lite register offsets
// ==============================
`define BF_ADDR_OPA    5'h00
`define BF_ADDR_OPB    5'h04
// A write here issues one command
`define BF_ADDR_CTRL   5'h08
`define BF_ADDR_STATUS 5'h0C
// A read here pops the result FIFO
`define BF_ADDR_RESULT 5'h10

`endif

/* design/bitfieldPkg.sv */
`default_nettype none

`include "bitfield_macros.svh"

package bitfieldPkg;

	// One operand or result word
	typedef logic [`BF_WIDTH-1:0] bfValue;

	// Bit position inside a word, used for mb and me
	typedef logic [4:0] bfPos;

	// Immediate field of the control word
	typedef logic [6:0] bfImm;

	// Lane index, wide enough for every lane
	typedef logic [$clog2(`BF_LANES)-1:0] laneIdx;

	// FIFO fill level, one bit wider than the index so that full fits
	typedef logic [$clog2(`BF_FIFO_DEPTH):0] bfCount;

	// Operation codes, as held in bits 3:0 of the control word
	typedef enum logic [3:0] {
		BFCLR  = 4'd0,
		BFSET  = 4'd1,
		BFCHG  = 4'd2,
		BFEXT  = 4'd3,
		BFINS  = 4'd4,
		BFINSI = 4'd5,
		BFFFO  = 4'd6,
		BFNOP  = 4'd7
	} bfOp;

	// Write side of the register block
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ISSUE,
		WR_RESP
	} axiWrState;

	// Read side of the register block
	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} axiRdState;

endpackage

`default_nettype wire

/* design/bitfieldRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldRegs (
	input wire clk,
	input wire arstN,
	// AXI4-Lite write address and data
	input wire [4:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire bitfieldPkg::bfValue wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	// AXI4-Lite read address and data
	input wire [4:0] araddr,
	input wire arvalid,
	output logic arready,
	output bitfieldPkg::bfValue rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready,
	// Command towards the dispatcher
	output logic cmdValid,
	output bitfieldPkg::bfOp cmdOp,
	output bitfieldPkg::bfValue cmdA,
	output bitfieldPkg::bfValue cmdB,
	output bitfieldPkg::bfPos cmdMb,
	output bitfieldPkg::bfPos cmdMe,
	output logic cmdSignExt,
	output bitfieldPkg::bfImm cmdImm,
	input wire cmdReady,
	// Result FIFO in the collector
	input wire bitfieldPkg::bfCount fifoCount,
	output logic fifoPop,
	input wire bitfieldPkg::bfValue fifoHead,
	input wire anyBusy
);

	import bitfieldPkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	axiWrState wrState;
	axiRdState rdState;
	bfValue opA;
	bfValue opB;
	bfValue ctrlReg;
	bfValue readWord;
	logic [1:0] readResp;
	logic wrHandshake;
	logic rdHandshake;
	logic fifoEmpty;

	// ==============================
	// Write side
	// ==============================

	// Address and data are taken together, and only while idle
	assign wrHandshake = (wrState == WR_IDLE) && awvalid && wvalid;
	assign awready = wrHandshake;
	assign wready = wrHandshake;

	// Writes always complete with OKAY once the response phase is reached
	assign bresp = RESP_OKAY;
	assign bvalid = (wrState == WR_RESP);

	// The command is offered for as long as the FSM waits in WR_ISSUE
	assign cmdValid = (wrState == WR_ISSUE);

	// Command fields are sliced out of the held control word
	assign cmdA = opA;
	assign cmdB = opB;
	assign cmdOp = bfOp'(ctrlReg[3:0]);
	assign cmdMb = ctrlReg[12:8];
	assign cmdMe = ctrlReg[20:16];
	assign cmdSignExt = ctrlReg[24];
	assign cmdImm = ctrlReg[31:25];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrState <= WR_IDLE;
			opA <= '0;
			opB <= '0;
			ctrlReg <= '0;
		end
		else
		begin
			case (wrState)
				WR_IDLE:
					if (wrHandshake)
					begin
						case (awaddr)
							`BF_ADDR_OPA: opA <= wdata;
							`BF_ADDR_OPB: opB <= wdata;
							`BF_ADDR_CTRL: ctrlReg <= wdata;
							default: ;
						endcase
						// Only a control write has a command to hand over
						wrState <= (awaddr == `BF_ADDR_CTRL) ? WR_ISSUE : WR_RESP;
					end
				// The response waits until a lane has taken the command
				WR_ISSUE:
					if (cmdReady)
						wrState <= WR_RESP;
				WR_RESP:
					if (bready)
						wrState <= WR_IDLE;
				default:
					wrState <= WR_IDLE;
			endcase
		end
	end

	// ==============================
	// Read side
	// ==============================

	assign arready = (rdState == RD_IDLE);
	assign rvalid = (rdState == RD_RESP);
	assign rdHandshake = arvalid && arready;
	assign fifoEmpty = (fifoCount == '0);

	// An empty FIFO is never popped, the read just reports the error
	assign fifoPop = rdHandshake && (araddr == `BF_ADDR_RESULT) && !fifoEmpty;

	always_comb
	begin
		readWord = '0;
		readResp = RESP_OKAY;
		case (araddr)
			`BF_ADDR_OPA: readWord = opA;
			`BF_ADDR_OPB: readWord = opB;
			`BF_ADDR_CTRL: readWord = ctrlReg;
			`BF_ADDR_STATUS:
			begin
				// Fill level sits in the low bits, the busy flag in bit 8
				readWord = bfValue'(fifoCount);
				readWord[8] = anyBusy;
			end
			`BF_ADDR_RESULT:
				if (fifoEmpty)
					readResp = RESP_SLVERR;
				else
					readWord = fifoHead;
			default: readResp = RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			rdState <= RD_IDLE;
		else if (rdHandshake)
			rdState <= RD_RESP;
		else if (rvalid && rready)
			rdState <= RD_IDLE;
	end

	// Read data is captured at the address handshake and shown next cycle
	always_ff @(posedge clk)
	begin
		if (rdHandshake)
		begin
			rdata <= readWord;
			rresp <= readResp;
		end
	end

	// Both responses stay up until the host takes them
	rvalidHold: assert property (@(posedge clk) disable iff (!arstN)
		rvalid && !rready |=> rvalid && $stable(rdata));
	bvalidHold: assert property (@(posedge clk) disable iff (!arstN)
		bvalid && !bready |=> bvalid);

	// A pending command keeps its fields until a lane accepts it
	cmdHold: assert property (@(posedge clk) disable iff (!arstN)
		cmdValid && !cmdReady |=> cmdValid && $stable({cmdOp, cmdA, cmdB, ctrlReg}));

endmodule

`default_nettype wire

/* design/bitfieldDispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldDispatch (
	input wire clk,
	input wire arstN,
	input wire cmdValid,
	output logic cmdReady,
	output logic [`BF_LANES-1:0] laneInValid,
	input wire [`BF_LANES-1:0] laneBusy
);

	import bitfieldPkg::*;

	// Lane that gets the next command
	laneIdx nextLane;
	logic accept;

	// Commands never skip a busy lane, so lanes fill in strict rotation
	assign cmdReady = !laneBusy[nextLane];
	assign accept = cmdValid && cmdReady;

	always_comb
	begin
		laneInValid = '0;
		laneInValid[nextLane] = accept;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			nextLane <= '0;
		else if (accept)
		begin
			// Wrap explicitly so a lane count that is not a power of two still works
			if (nextLane == laneIdx'(`BF_LANES - 1))
				nextLane <= '0;
			else
				nextLane <= nextLane + 1'b1;
		end
	end

	// A command is handed to a single lane
	oneLane: assert property (@(posedge clk) disable iff (!arstN)
		$onehot0(laneInValid));

endmodule

`default_nettype wire

/* design/bitfieldLane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldLane (
	input wire clk,
	input wire arstN,
	input wire inValid,
	input wire bitfieldPkg::bfOp op,
	input wire bitfieldPkg::bfValue a,
	input wire bitfieldPkg::bfValue b,
	input wire bitfieldPkg::bfPos mb,
	input wire bitfieldPkg::bfPos me,
	input wire signExt,
	input wire bitfieldPkg::bfImm imm,
	output logic outValid,
	output bitfieldPkg::bfValue result,
	input wire outAck,
	output logic busy
);

	import bitfieldPkg::*;

	bfValue mask;
	bfValue resultNext;
	bfValue insField;
	bfValue maskedA;
	logic [2*`BF_WIDTH-1:0] pair;
	bfPos ffoIdx;
	logic ffoFound;

	// ==============================
	// Field mask
	// ==============================

	// Bits mb through me, wrapping past the top when me is below mb
	always_comb
	begin
		for (int n = 0; n < `BF_WIDTH; n++)
		begin
			if (me >= mb)
				mask[n] = (n >= mb) && (n <= me);
			else
				mask[n] = (n >= mb) || (n <= me);
		end
	end

	// Register value or immediate, moved up to the start of the field
	assign insField = (op == BFINSI) ? (bfValue'(imm) << mb) : (b << mb);

	// Operand pair for extraction, b above a
	assign pair = {b, a} >> mb;

	assign maskedA = a & mask;

	// Highest set bit of the masked operand, later bits overwrite earlier ones
	always_comb
	begin
		ffoIdx = '0;
		ffoFound = 1'b0;
		for (int n = 0; n < `BF_WIDTH; n++)
		begin
			if (maskedA[n])
			begin
				ffoIdx = bfPos'(n);
				ffoFound = 1'b1;
			end
		end
	end

	// ==============================
	// Operation select
	// ==============================

	always_comb
	begin
		resultNext = '0;
		case (op)
			BFCLR: resultNext = a & ~mask;
			BFSET: resultNext = a | mask;
			BFCHG: resultNext = a ^ mask;
			BFEXT:
				// Keep bits 0 to me and fill above from bit me or with zero
				for (int n = 0; n < `BF_WIDTH; n++)
				begin
					if (n > me)
						resultNext[n] = signExt ? pair[me] : 1'b0;
					else
						resultNext[n] = pair[n];
				end
			BFINS, BFINSI: resultNext = (a & ~mask) | (insField & mask);
			// No bit set gives all ones
			BFFFO: resultNext = ffoFound ? bfValue'(ffoIdx) - bfValue'(mb) : '1;
			default: resultNext = '0;
		endcase
	end

	// Result is only loaded on issue, so a held result is never overwritten
	always_ff @(posedge clk)
	begin
		if (inValid)
			result <= resultNext;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (inValid)
			outValid <= 1'b1;
		else if (outAck)
			outValid <= 1'b0;
	end

	// The lane counts as busy while its result waits for the collector
	assign busy = outValid;

	// The dispatcher must never hand work to a lane with a pending result
	noIssueWhenBusy: assert property (@(posedge clk) disable iff (!arstN)
		inValid |-> !busy);

endmodule

`default_nettype wire

/* design/bitfieldCollect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldCollect (
	input wire clk,
	input wire arstN,
	input wire [`BF_LANES-1:0] laneOutValid,
	input wire bitfieldPkg::bfValue laneResult [`BF_LANES],
	output logic [`BF_LANES-1:0] laneOutAck,
	input wire fifoPop,
	output bitfieldPkg::bfCount fifoCount,
	output bitfieldPkg::bfValue fifoHead
);

	import bitfieldPkg::*;

	localparam int PTR_W = $clog2(`BF_FIFO_DEPTH);

	bfValue mem [`BF_FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	laneIdx expLane;
	logic fifoFull;
	logic push;

	// Lanes are drained in the same rotation the dispatcher issues them
	assign fifoFull = (fifoCount == bfCount'(`BF_FIFO_DEPTH));
	assign push = laneOutValid[expLane] && !fifoFull;

	always_comb
	begin
		laneOutAck = '0;
		laneOutAck[expLane] = push;
	end

	assign fifoHead = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= laneResult[expLane];
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			expLane <= '0;
			fifoCount <= '0;
		end
		else
		begin
			if (push)
			begin
				wrPtr <= (wrPtr == PTR_W'(`BF_FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
				expLane <= (expLane == laneIdx'(`BF_LANES - 1)) ? '0 : expLane + 1'b1;
			end
			if (fifoPop)
				rdPtr <= (rdPtr == PTR_W'(`BF_FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			// Push and pop in one cycle leave the count unchanged
			if (push && !fifoPop)
				fifoCount <= fifoCount + 1'b1;
			else if (fifoPop && !push)
				fifoCount <= fifoCount - 1'b1;
		end
	end

	// The fill level never climbs past the depth, so a full FIFO takes no push
	noPushFull: assert property (@(posedge clk) disable iff (!arstN)
		fifoCount <= bfCount'(`BF_FIFO_DEPTH));

	// The register block only pops what is there
	noPopEmpty: assert property (@(posedge clk) disable iff (!arstN)
		fifoPop |-> fifoCount != '0);

endmodule

`default_nettype wire

/* design/bitfieldEngine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldEngine (
	input wire clk,
	input wire arstN,
	input wire [4:0] awaddr,
	input wire awvalid,
	output logic awready,
	input wire bitfieldPkg::bfValue wdata,
	input wire wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire bready,
	input wire [4:0] araddr,
	input wire arvalid,
	output logic arready,
	output bitfieldPkg::bfValue rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire rready
);

	import bitfieldPkg::*;

	// Command shared by all lanes
	logic cmdValid;
	logic cmdReady;
	bfOp cmdOp;
	bfValue cmdA;
	bfValue cmdB;
	bfPos cmdMb;
	bfPos cmdMe;
	logic cmdSignExt;
	bfImm cmdImm;

	// Per-lane handshakes
	logic [`BF_LANES-1:0] laneInValid;
	logic [`BF_LANES-1:0] laneBusy;
	logic [`BF_LANES-1:0] laneOutValid;
	logic [`BF_LANES-1:0] laneOutAck;
	bfValue laneResult [`BF_LANES];

	// Result FIFO
	bfCount fifoCount;
	bfValue fifoHead;
	logic fifoPop;
	logic anyBusy;

	// STATUS reports whether any lane still holds a result
	assign anyBusy = |laneBusy;

	bitfieldRegs regs (
		.clk(clk), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.cmdValid(cmdValid), .cmdOp(cmdOp), .cmdA(cmdA), .cmdB(cmdB),
		.cmdMb(cmdMb), .cmdMe(cmdMe), .cmdSignExt(cmdSignExt), .cmdImm(cmdImm),
		.cmdReady(cmdReady),
		.fifoCount(fifoCount), .fifoPop(fifoPop), .fifoHead(fifoHead),
		.anyBusy(anyBusy)
	);

	bitfieldDispatch dispatch (
		.clk(clk), .arstN(arstN),
		.cmdValid(cmdValid), .cmdReady(cmdReady),
		.laneInValid(laneInValid), .laneBusy(laneBusy)
	);

	// Every lane sees the same command, only its own valid differs
	for (genvar i = 0; i < `BF_LANES; i++)
	begin : genLane
		bitfieldLane lane (
			.clk(clk), .arstN(arstN),
			.inValid(laneInValid[i]),
			.op(cmdOp), .a(cmdA), .b(cmdB), .mb(cmdMb), .me(cmdMe),
			.signExt(cmdSignExt), .imm(cmdImm),
			.outValid(laneOutValid[i]), .result(laneResult[i]),
			.outAck(laneOutAck[i]), .busy(laneBusy[i])
		);
	end

	bitfieldCollect collect (
		.clk(clk), .arstN(arstN),
		.laneOutValid(laneOutValid), .laneResult(laneResult), .laneOutAck(laneOutAck),
		.fifoPop(fifoPop), .fifoCount(fifoCount), .fifoHead(fifoHead)
	);

endmodule

`default_nettype wire

/* verification/bitfieldChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldChecker (
	input wire clk,
	input wire arstN,
	// Commands announced by the driver just before their CTRL write
	input wire issueStrobe,
	input wire [31:0] issueCtrl,
	input wire [31:0] issueA,
	input wire [31:0] issueB,
	input wire issueHasExp,
	input wire [31:0] issueExp,
	// Expected STATUS word, only compared while statusCheck is high
	input wire statusCheck,
	input wire [31:0] statusExp,
	// AXI4-Lite read channel of the DUT
	input wire [4:0] araddr,
	input wire arvalid,
	input wire arready,
	input wire [31:0] rdata,
	input wire [1:0] rresp,
	input wire rvalid,
	input wire rready,
	output int errorCount,
	output int compareCount
);

	import bitfieldPkg::*;

	// One issued command, with the hand-written result when the table gave one
	typedef struct packed {
		logic [31:0] ctrl;
		logic [31:0] a;
		logic [31:0] b;
		logic hasExp;
		logic [31:0] expVal;
	} issuedCmd;

	issuedCmd cmdQ [$];
	logic [4:0] lastAddr = 5'h00;
	int mismatches = 0;
	int compares = 0;

	assign errorCount = mismatches;
	assign compareCount = compares;

	// ==============================
	// Reference model
	// ==============================

	// Field from mb up to me; a wrapped field is the union of both halves
	function automatic logic [31:0] fieldMask(input logic [4:0] mb, input logic [4:0] me);
		logic [31:0] fromMb;
		logic [31:0] toMe;
		fromMb = 32'hFFFF_FFFF << mb;
		toMe = 32'hFFFF_FFFF >> (5'd31 - me);
		return (me >= mb) ? (fromMb & toMe) : (fromMb | toMe);
	endfunction

	function automatic logic [31:0] expectedResult(input logic [31:0] ctrl,
		input logic [31:0] a, input logic [31:0] b);
		logic [4:0] mb;
		logic [4:0] me;
		logic [31:0] mask;
		logic [31:0] imm;
		logic [63:0] pair;
		logic [31:0] r;
		int top;
		mb = ctrl[12:8];
		me = ctrl[20:16];
		imm = {25'd0, ctrl[31:25]};
		mask = fieldMask(mb, me);
		pair = {b, a} >> mb;
		r = 32'h0;
		top = -1;
		case (bfOp'(ctrl[3:0]))
			BFCLR: r = a & ~mask;
			BFSET: r = a | mask;
			BFCHG: r = a ^ mask;
			BFEXT:
				for (int n = 0; n < 32; n++)
					r[n] = (n <= int'(me)) ? pair[n] : (ctrl[24] & pair[me]);
			BFINS: r = (a & ~mask) | ((b << mb) & mask);
			BFINSI: r = (a & ~mask) | ((imm << mb) & mask);
			BFFFO:
			begin
				// Scan down from the top so the first hit is the highest bit
				for (int n = 31; n >= 0; n--)
					if (top < 0 && mask[n] && a[n])
						top = n;
				r = (top < 0) ? 32'hFFFF_FFFF : 32'(top) - 32'(mb);
			end
			default: r = 32'h0;
		endcase
		return r;
	endfunction

	task automatic flagMismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, want);
		mismatches++;
	endtask

	// ==============================
	// Monitor
	// ==============================

	always @(posedge clk)
	begin : monitor
		issuedCmd rec;
		logic [31:0] want;
		if (arstN)
		begin
			if (issueStrobe)
				cmdQ.push_back('{issueCtrl, issueA, issueB, issueHasExp, issueExp});
			if (rvalid && rready && lastAddr == `BF_ADDR_RESULT)
			begin
				if (cmdQ.size() == 0)
				begin
					// Nothing outstanding, so this read hits an empty FIFO
					if (rresp != 2'b10)
						flagMismatch("rresp", 32'(rresp), 32'h2);
					if (rdata !== 32'h0)
						flagMismatch("rdata", rdata, 32'h0);
				end
				else
				begin
					rec = cmdQ.pop_front();
					want = expectedResult(rec.ctrl, rec.a, rec.b);
					compares++;
					if (rresp != 2'b00)
						flagMismatch("rresp", 32'(rresp), 32'h0);
					if (rdata !== want)
						flagMismatch("rdata", rdata, want);
					// Table entries also carry a value worked out by hand
					if (rec.hasExp && rdata !== rec.expVal)
						flagMismatch("rdata", rdata, rec.expVal);
				end
			end
			if (rvalid && rready && lastAddr == `BF_ADDR_STATUS && statusCheck)
				if (rdata !== statusExp)
					flagMismatch("rdata", rdata, statusExp);
			// The response always comes at least one edge after its address
			if (arvalid && arready)
				lastAddr = araddr;
		end
	end

endmodule

`default_nettype wire

/* verification/bitfieldEngineTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bitfield_macros.svh"

module bitfieldEngineTb;

	import bitfieldPkg::*;

	localparam int TABLE_LEN = 17;
	localparam int RANDOM_COUNT = 200;
	// Results the engine can hold before a CTRL write stalls
	localparam int HOLD_LIMIT = `BF_FIFO_DEPTH + `BF_LANES;
	localparam int WATCHDOG_CYCLES = (TABLE_LEN + RANDOM_COUNT) * 40 + 1000;

	typedef struct packed {
		logic [3:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] mb;
		logic [4:0] me;
		logic sx;
		logic [6:0] imm;
		logic [31:0] expVal;
	} stimEntry;

	logic clk = 1'b0;
	logic arstN;
	logic [4:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [4:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Side channel to the checker
	logic issueStrobe;
	logic [31:0] issueCtrl;
	logic [31:0] issueA;
	logic [31:0] issueB;
	logic issueHasExp;
	logic [31:0] issueExp;
	logic statusCheck;
	logic [31:0] statusExp;
	int checkErrors;
	int compareCount;

	stimEntry stimTable [TABLE_LEN];
	int entryCount = 0;
	int outstanding = 0;
	int protocolErrors = 0;
	logic [31:0] rngState = 32'ha034;

	bitfieldEngine uut (
		.clk(clk), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	bitfieldChecker chk (
		.clk(clk), .arstN(arstN),
		.issueStrobe(issueStrobe), .issueCtrl(issueCtrl),
		.issueA(issueA), .issueB(issueB),
		.issueHasExp(issueHasExp), .issueExp(issueExp),
		.statusCheck(statusCheck), .statusExp(statusExp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.errorCount(checkErrors), .compareCount(compareCount)
	);

	always #5 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// The control word holds op in 3:0, mb in 12:8, me in 20:16, signExt in 24 and imm in 31:25
	function automatic logic [31:0] ctrlWord(input logic [3:0] op, input logic [4:0] mb,
		input logic [4:0] me, input logic sx, input logic [6:0] imm);
		return {imm, sx, 3'b000, me, 3'b000, mb, 4'b0000, op};
	endfunction

	task automatic protocolFailure(input string what);
		$display("ERROR at %0d ns: %s", $time, what);
		protocolErrors++;
	endtask

	task automatic addEntry(input logic [3:0] op, input logic [31:0] a, input logic [31:0] b,
		input logic [4:0] mb, input logic [4:0] me, input logic sx, input logic [6:0] imm,
		input logic [31:0] expVal);
		stimTable[entryCount] = '{op, a, b, mb, me, sx, imm, expVal};
		entryCount++;
	endtask

	// Address and data go out together and the DUT takes both in one cycle
	task automatic startWrite(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
	endtask

	// bready is held high, so a visible bvalid completes the response
	task automatic awaitWriteResp(input int limit, output bit seen);
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++)
		begin
			@(posedge clk);
			if (bvalid)
			begin
				seen = 1'b1;
				if (bresp != 2'b00)
					protocolFailure("write response was not OKAY");
			end
		end
	endtask

	task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
		bit seen;
		startWrite(addr, data);
		awaitWriteResp(100, seen);
		if (!seen)
			protocolFailure("write response never arrived");
	endtask

	task automatic readReg(input logic [4:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
	endtask

	task automatic checkStatus(input logic [31:0] expected);
		logic [31:0] d;
		logic [1:0] r;
		statusExp <= expected;
		statusCheck <= 1'b1;
		readReg(`BF_ADDR_STATUS, d, r);
		statusCheck <= 1'b0;
	endtask

	// Tells the checker about a command one cycle ahead of its CTRL write
	task automatic noteCommand(input logic [31:0] ctrl, input logic [31:0] a,
		input logic [31:0] b, input logic hasExp, input logic [31:0] expVal);
		@(posedge clk);
		issueCtrl <= ctrl;
		issueA <= a;
		issueB <= b;
		issueHasExp <= hasExp;
		issueExp <= expVal;
		issueStrobe <= 1'b1;
		@(posedge clk);
		issueStrobe <= 1'b0;
	endtask

	task automatic loadOperands(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] ctrl, input logic hasExp, input logic [31:0] expVal);
		writeReg(`BF_ADDR_OPA, a);
		writeReg(`BF_ADDR_OPB, b);
		noteCommand(ctrl, a, b, hasExp, expVal);
	endtask

	task automatic sendCommand(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] ctrl, input logic hasExp, input logic [31:0] expVal);
		loadOperands(a, b, ctrl, hasExp, expVal);
		writeReg(`BF_ADDR_CTRL, ctrl);
		outstanding++;
	endtask

	task automatic applyEntry(input int idx);
		stimEntry e;
		e = stimTable[idx];
		sendCommand(e.a, e.b, ctrlWord(e.op, e.mb, e.me, e.sx, e.imm), 1'b1, e.expVal);
	endtask

	// Waits on STATUS until a result has reached the FIFO, then pops it
	task automatic popResult();
		logic [31:0] d;
		logic [1:0] r;
		do
			readReg(`BF_ADDR_STATUS, d, r);
		while (d[3:0] == 4'd0);
		readReg(`BF_ADDR_RESULT, d, r);
		outstanding--;
	endtask

	task automatic buildTable();
		// Normal and wrapping masks for the three mask operations
		addEntry(BFCLR, 32'hFFFFFFFF, 32'h0, 5'd4, 5'd11, 1'b0, 7'h00, 32'hFFFFF00F);
		addEntry(BFCLR, 32'hFFFFFFFF, 32'h0, 5'd28, 5'd3, 1'b0, 7'h00, 32'h0FFFFFF0);
		addEntry(BFSET, 32'h00000000, 32'h0, 5'd8, 5'd15, 1'b0, 7'h00, 32'h0000FF00);
		addEntry(BFSET, 32'h12345678, 32'h0, 5'd30, 5'd1, 1'b0, 7'h00, 32'hD234567B);
		addEntry(BFCHG, 32'hAAAAAAAA, 32'h0, 5'd0, 5'd31, 1'b0, 7'h00, 32'h55555555);
		addEntry(BFCHG, 32'h0000FFFF, 32'h0, 5'd16, 5'd7, 1'b0, 7'h00, 32'hFFFFFF00);
		// Extraction across the a/b boundary, then a positive signed field
		addEntry(BFEXT, 32'hF0000000, 32'hA, 5'd28, 5'd7, 1'b0, 7'h00, 32'h000000AF);
		addEntry(BFEXT, 32'hF0000000, 32'hA, 5'd28, 5'd7, 1'b1, 7'h00, 32'hFFFFFFAF);
		addEntry(BFEXT, 32'h00000350, 32'h0, 5'd4, 5'd7, 1'b1, 7'h00, 32'h00000035);
		addEntry(BFINS, 32'hFFFFFFFF, 32'h5, 5'd8, 5'd11, 1'b0, 7'h00, 32'hFFFFF5FF);
		addEntry(BFINS, 32'h00000000, 32'hAB, 5'd28, 5'd3, 1'b0, 7'h00, 32'hB0000000);
		addEntry(BFINSI, 32'h12345678, 32'h0, 5'd4, 5'd9, 1'b0, 7'h7F, 32'h123457F8);
		addEntry(BFINSI, 32'hFFFFFFFF, 32'h0, 5'd0, 5'd7, 1'b0, 7'h15, 32'hFFFFFF15);
		// Bit 20 found, nothing in the field, and a wrapped field below mb
		addEntry(BFFFO, 32'h00100000, 32'h0, 5'd4, 5'd27, 1'b0, 7'h00, 32'h00000010);
		addEntry(BFFFO, 32'h0000000F, 32'h0, 5'd8, 5'd31, 1'b0, 7'h00, 32'hFFFFFFFF);
		addEntry(BFFFO, 32'h00000003, 32'h0, 5'd30, 5'd5, 1'b0, 7'h00, 32'hFFFFFFE3);
		addEntry(BFNOP, 32'hDEADBEEF, 32'h1, 5'd3, 5'd9, 1'b1, 7'h11, 32'h00000000);
	endtask

	// ==============================
	// Watchdog
	// ==============================

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin : stimulus
		logic [31:0] d;
		logic [1:0] r;
		logic [31:0] randA;
		logic [31:0] randB;
		logic [31:0] fields;
		bit seen;
		stimEntry e;
		arstN = 1'b0;
		awaddr = 5'h0;
		awvalid = 1'b0;
		wdata = 32'h0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = 5'h0;
		arvalid = 1'b0;
		rready = 1'b1;
		issueStrobe = 1'b0;
		issueCtrl = 32'h0;
		issueA = 32'h0;
		issueB = 32'h0;
		issueHasExp = 1'b0;
		issueExp = 32'h0;
		statusCheck = 1'b0;
		statusExp = 32'h0;
		buildTable();
		repeat (10) @(posedge clk);
		arstN <= 1'b1;

		// The idle engine has an empty FIFO and no busy lane, and RESULT answers with SLVERR
		checkStatus(32'h0);
		readReg(`BF_ADDR_RESULT, d, r);

		// Each table entry on its own, read back right away
		for (int i = 0; i < TABLE_LEN; i++)
		begin
			applyEntry(i);
			popResult();
		end

		// Fill the FIFO and every lane without reading anything
		for (int i = 0; i < HOLD_LIMIT; i++)
			applyEntry(i);
		do
			readReg(`BF_ADDR_STATUS, d, r);
		while (d[3:0] != 4'(`BF_FIFO_DEPTH));
		checkStatus(32'h100 | 32'(`BF_FIFO_DEPTH));

		// One more CTRL write has to wait until a RESULT read makes room
		e = stimTable[HOLD_LIMIT];
		loadOperands(e.a, e.b, ctrlWord(e.op, e.mb, e.me, e.sx, e.imm), 1'b1, e.expVal);
		startWrite(`BF_ADDR_CTRL, ctrlWord(e.op, e.mb, e.me, e.sx, e.imm));
		awaitWriteResp(20, seen);
		if (seen)
			protocolFailure("CTRL write completed while the result FIFO was full");
		popResult();
		awaitWriteResp(100, seen);
		if (!seen)
			protocolFailure("stalled CTRL write did not complete after a RESULT read");
		outstanding++;
		while (outstanding > 0)
			popResult();

		// Random commands with reads mixed in at random
		for (int i = 0; i < RANDOM_COUNT; i++)
		begin
			rngState = xorshift(rngState);
			randA = rngState;
			rngState = xorshift(rngState);
			randB = rngState;
			rngState = xorshift(rngState);
			fields = rngState;
			sendCommand(randA, randB,
				ctrlWord({1'b0, fields[2:0]}, fields[12:8], fields[20:16], fields[24],
				fields[31:25]), 1'b0, 32'h0);
			// Staying below HOLD_LIMIT keeps the CTRL write from stalling here
			if (fields[5] || outstanding >= HOLD_LIMIT - 2)
				popResult();
		end
		while (outstanding > 0)
			popResult();

		// Drained again, so the engine looks as it did after reset
		readReg(`BF_ADDR_RESULT, d, r);
		checkStatus(32'h0);
		repeat (2) @(posedge clk);

		$display("Errors: %0d in checked values, %0d in protocol, %0d results compared",
			checkErrors, protocolErrors, compareCount);
		if (checkErrors == 0 && protocolErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* bitfieldEngine.f */
+incdir+design
design/bitfieldPkg.sv
design/bitfieldRegs.sv
design/bitfieldDispatch.sv
design/bitfieldLane.sv
design/bitfieldCollect.sv
design/bitfieldEngine.sv
verification/bitfieldChecker.sv
verification/bitfieldEngineTb.sv

/* run.sh */
#!/bin/bash
# Builds the bitfield engine testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f bitfieldEngine.f \
	--top-module bitfieldEngineTb -Mdir obj_dir -o bitfieldSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/bitfieldSim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log && { echo "PASS"; exit 0; } \
	|| { echo "FAIL: no result line in sim.log"; exit 1; }
